/* common/busDefines.svh */
//****************************
// Bus system constants
// Widths, address map, stopwatch divider,
// LFSR constants and stopwatch commands
//****************************
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// Data path widths
`define BUS_WIDTH     32
`define BYTE_LANES    4

// Data memory window
`define MEM_WORDS     256
`define MEM_BASE      32'h1001_0000

// Memory-mapped device registers
`define SW_ADDR       32'hFF20_0510
`define LFSR_ADDR     32'hFF20_0514
`define DISP_ADDR     32'hFF20_0518

// CLOCK_50 cycles per stopwatch tick
`define SW_TICK_DIV   5

// Stopwatch command words
`define SW_CMD_STOP   32'd0
`define SW_CMD_RUN    32'd1
`define SW_CMD_CLEAR  32'd2

// Galois LFSR
`define LFSR_TAPS     32'h8020_0003
`define LFSR_SEED     32'hACE1_2345

// Read strobe to readValid
`define READ_LATENCY  2

`endif

/* common/busPkg.sv */
//****************************
// Bus system types
// Bus words, byte lanes, segment digits
// and device enums
//****************************
`default_nettype none

`include "busDefines.svh"

package busPkg;

    // One bus data or address word
    typedef logic [`BUS_WIDTH-1:0] busWord_t;

    // Write mask, one bit per byte lane
    typedef logic [`BYTE_LANES-1:0] byteEnable_t;

    // Active-low digit, bit 0 = a .. bit 6 = g
    typedef logic [6:0] segment_t;

    // Stopwatch run/stop FSM
    typedef enum logic {
        swStopped,
        swRunning
    } swState_t;

    // Display source, from the board switches
    typedef enum logic [1:0] {
        dispBlank     = 2'd0,
        dispRegister  = 2'd1,
        dispStopwatch = 2'd2,
        dispZero      = 2'd3
    } dispSource_t;

endpackage

`default_nettype wire

/* common/busIf.sv */
//****************************
// Data bus request
// One registered request plus one-hot
// device selects, valid for one cycle
//****************************
`timescale 1ns/1ps
`default_nettype none

interface busIf import busPkg::*; ();

    // Request fields
    logic        readEnable;
    logic        writeEnable;
    byteEnable_t byteEnable;
    busWord_t    address;
    busWord_t    writeData;

    // Decoded device selects
    logic        memSel;
    logic        swSel;
    logic        lfsrSel;
    logic        dispSel;

    // Bus master side
    modport ctrl (
        output readEnable, writeEnable, byteEnable, address, writeData,
        output memSel, swSel, lfsrSel, dispSel
    );

    // Slave side
    modport device (
        input readEnable, writeEnable, byteEnable, address, writeData,
        input memSel, swSel, lfsrSel, dispSel
    );

endinterface

`default_nettype wire

/* rtl/busController.sv */
//****************************
// Bus controller
// Decodes the address map, registers the
// request onto the device bus and returns
// the selected device word two cycles on
//****************************
`timescale 1ns/1ps
`default_nettype none

`include "busDefines.svh"

module busController import busPkg::*; (
    input  logic        CLOCK_50,
    input  logic        rstN,
    input  logic        readEnable,
    input  logic        writeEnable,
    input  byteEnable_t byteEnable,
    input  busWord_t    address,
    input  busWord_t    writeData,
    busIf.ctrl          bus,
    input  busWord_t    memData,
    input  busWord_t    swData,
    input  busWord_t    lfsrData,
    input  busWord_t    dispData,
    output busWord_t    readData,
    output logic        readValid
);

    // First byte past the data memory window
    localparam busWord_t MemLimit = `MEM_BASE + `MEM_WORDS * `BYTE_LANES;

    logic request;
    logic hitMem;
    logic hitSw;
    logic hitLfsr;
    logic hitDisp;

    // Second stage read selects
    logic memRdQ;
    logic swRdQ;
    logic lfsrRdQ;
    logic dispRdQ;

    // Address decode, only while a strobe is present
    assign request = readEnable | writeEnable;
    assign hitMem  = request && (address >= `MEM_BASE) && (address < MemLimit);
    assign hitSw   = request && (address == `SW_ADDR);
    assign hitLfsr = request && (address == `LFSR_ADDR);
    assign hitDisp = request && (address == `DISP_ADDR);

    // Stage 1 strobes and selects
    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            bus.readEnable  <= 1'b0;
            bus.writeEnable <= 1'b0;
            bus.memSel      <= 1'b0;
            bus.swSel       <= 1'b0;
            bus.lfsrSel     <= 1'b0;
            bus.dispSel     <= 1'b0;
        end else begin
            bus.readEnable  <= readEnable;
            bus.writeEnable <= writeEnable;
            bus.memSel      <= hitMem;
            bus.swSel       <= hitSw;
            bus.lfsrSel     <= hitLfsr;
            bus.dispSel     <= hitDisp;
        end
    end

    // Stage 1 payload
    always_ff @(posedge CLOCK_50) begin
        bus.byteEnable <= byteEnable;
        bus.address    <= address;
        bus.writeData  <= writeData;
    end

    // Stage 2, matches the device read register
    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            readValid <= 1'b0;
            memRdQ    <= 1'b0;
            swRdQ     <= 1'b0;
            lfsrRdQ   <= 1'b0;
            dispRdQ   <= 1'b0;
        end else begin
            readValid <= bus.readEnable;
            memRdQ    <= bus.readEnable & bus.memSel;
            swRdQ     <= bus.readEnable & bus.swSel;
            lfsrRdQ   <= bus.readEnable & bus.lfsrSel;
            dispRdQ   <= bus.readEnable & bus.dispSel;
        end
    end

    // Return mux; unmapped reads give zero
    always_comb begin
        readData = '0;
        if (memRdQ) begin
            readData = memData;
        end else if (swRdQ) begin
            readData = swData;
        end else if (lfsrRdQ) begin
            readData = lfsrData;
        end else if (dispRdQ) begin
            readData = dispData;
        end
    end

    // Master never strobes read and write together
    rdWrExclusive: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        !(readEnable && writeEnable));

    // At most one device sees the registered request
    selOneHot: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        $onehot0({bus.memSel, bus.swSel, bus.lfsrSel, bus.dispSel}));

endmodule

`default_nettype wire

/* rtl/dataMemory.sv */
//****************************
// Data memory
// Word RAM with byte-lane writes and
// a registered read port
//****************************
`timescale 1ns/1ps
`default_nettype none

`include "busDefines.svh"

module dataMemory import busPkg::*; (
    input  logic     CLOCK_50,
    busIf.device     bus,
    output busWord_t rData
);

    localparam int IndexBits  = $clog2(`MEM_WORDS);
    localparam int OffsetBits = $clog2(`BYTE_LANES);

    busWord_t             mem [`MEM_WORDS];
    logic [IndexBits-1:0] index;

    // Word index, above the byte offset
    assign index = bus.address[OffsetBits +: IndexBits];

    always_ff @(posedge CLOCK_50) begin
        // Only enabled lanes change
        if (bus.writeEnable && bus.memSel) begin
            for (int lane = 0; lane < `BYTE_LANES; lane++) begin
                if (bus.byteEnable[lane]) begin
                    mem[index][lane*8 +: 8] <= bus.writeData[lane*8 +: 8];
                end
            end
        end
        // Read word held until the next read
        if (bus.readEnable && bus.memSel) begin
            rData <= mem[index];
        end
    end

endmodule

`default_nettype wire

/* stopwatch/stopwatchControl.sv */
//****************************
// Stopwatch controller
// Run/stop FSM driven by command writes,
// with a one-cycle clear pulse
//****************************
`timescale 1ns/1ps
`default_nettype none

`include "busDefines.svh"

module stopwatchControl import busPkg::*; (
    input  logic CLOCK_50,
    input  logic rstN,
    busIf.device bus,
    output logic run,
    output logic clear
);

    swState_t state;
    swState_t stateNext;
    logic     cmdWrite;
    logic     clearNext;

    // Command write to the stopwatch register
    assign cmdWrite = bus.writeEnable && bus.swSel;

    always_comb begin
        stateNext = state;
        clearNext = 1'b0;
        if (cmdWrite) begin
            case (bus.writeData)
                `SW_CMD_RUN:  stateNext = swRunning;
                `SW_CMD_STOP: stateNext = swStopped;
                `SW_CMD_CLEAR: begin
                    // Clear also stops
                    stateNext = swStopped;
                    clearNext = 1'b1;
                end
                default: stateNext = state;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            state <= swStopped;
            clear <= 1'b0;
        end else begin
            state <= stateNext;
            clear <= clearNext;
        end
    end

    assign run = (state == swRunning);

    // Timer never counts on the clear cycle
    clearStops: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        clear |-> !run);

endmodule

`default_nettype wire

/* stopwatch/stopwatchTimer.sv */
//****************************
// Stopwatch timer
// Prescaler and elapsed-tick counter
// with a registered read port
//****************************
`timescale 1ns/1ps
`default_nettype none

`include "busDefines.svh"

module stopwatchTimer import busPkg::*; (
    input  logic     CLOCK_50,
    input  logic     rstN,
    busIf.device     bus,
    input  logic     run,
    input  logic     clear,
    output busWord_t rData,
    output busWord_t swCount
);

    localparam int PreBits = $clog2(`SW_TICK_DIV + 1);
    localparam logic [PreBits-1:0] PreLast = PreBits'(`SW_TICK_DIV - 1);

    logic [PreBits-1:0] prescale;

    // Both counters hold while stopped
    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            prescale <= '0;
            swCount  <= '0;
        end else if (clear) begin
            prescale <= '0;
            swCount  <= '0;
        end else if (run) begin
            if (prescale == PreLast) begin
                // One tick per SW_TICK_DIV cycles
                prescale <= '0;
                swCount  <= swCount + 1'b1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

    // Read during clear already sees zero
    always_ff @(posedge CLOCK_50) begin
        if (bus.readEnable && bus.swSel) begin
            rData <= clear ? '0 : swCount;
        end
    end

endmodule

`default_nettype wire

/* rtl/lfsrGenerator.sv */
//****************************
// LFSR random source
// 32-bit Galois LFSR, one step per read
//****************************
`timescale 1ns/1ps
`default_nettype none

`include "busDefines.svh"

module lfsrGenerator import busPkg::*; (
    input  logic     CLOCK_50,
    input  logic     rstN,
    busIf.device     bus,
    output busWord_t rData
);

    busWord_t lfsr;
    busWord_t lfsrNext;
    logic     stepEn;

    assign stepEn = bus.readEnable && bus.lfsrSel;

    // Shift right, fold taps back when a one drops out
    assign lfsrNext = (lfsr >> 1) ^ (lfsr[0] ? busWord_t'(`LFSR_TAPS) : '0);

    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            lfsr <= `LFSR_SEED;
        end else if (stepEn) begin
            lfsr <= lfsrNext;
        end
    end

    // Current value out, before the step
    always_ff @(posedge CLOCK_50) begin
        if (stepEn) begin
            rData <= lfsr;
        end
    end

endmodule

`default_nettype wire

/* rtl/displayDriver.sv */
//****************************
// Seven-segment display
// Display register, switch-selected source
// and six hex digits, active low
//****************************
`timescale 1ns/1ps
`default_nettype none

`include "busDefines.svh"

module displayDriver import busPkg::*; (
    input  logic        CLOCK_50,
    input  logic        rstN,
    busIf.device        bus,
    input  busWord_t    swCount,
    input  dispSource_t dispSelect,
    output busWord_t    rData,
    output segment_t    hex0,
    output segment_t    hex1,
    output segment_t    hex2,
    output segment_t    hex3,
    output segment_t    hex4,
    output segment_t    hex5
);

    busWord_t    dispReg;
    logic [23:0] digits;
    logic        blank;
    segment_t    segNext [6];

    // DE1 glyphs, bit 0 = a .. bit 6 = g
    function automatic segment_t hexToSeg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'hA: return 7'b0001000;
            4'hB: return 7'b0000011;
            4'hC: return 7'b1000110;
            4'hD: return 7'b0100001;
            4'hE: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // Display register, byte-lane writes
    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            dispReg <= '0;
        end else if (bus.writeEnable && bus.dispSel) begin
            for (int lane = 0; lane < `BYTE_LANES; lane++) begin
                if (bus.byteEnable[lane]) begin
                    dispReg[lane*8 +: 8] <= bus.writeData[lane*8 +: 8];
                end
            end
        end
    end

    // Read back
    always_ff @(posedge CLOCK_50) begin
        if (bus.readEnable && bus.dispSel) begin
            rData <= dispReg;
        end
    end

    // Source select from the switches
    always_comb begin
        blank  = 1'b0;
        digits = '0;
        case (dispSelect)
            dispBlank:     blank  = 1'b1;
            dispRegister:  digits = dispReg[23:0];
            dispStopwatch: digits = swCount[23:0];
            default:       digits = '0;
        endcase
    end

    // Blank is all segments off
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            segNext[i] = blank ? '1 : hexToSeg(digits[i*4 +: 4]);
        end
    end

    // Segments follow one cycle later
    always_ff @(posedge CLOCK_50) begin
        if (!rstN) begin
            hex0 <= '1;
            hex1 <= '1;
            hex2 <= '1;
            hex3 <= '1;
            hex4 <= '1;
            hex5 <= '1;
        end else begin
            hex0 <= segNext[0];
            hex1 <= segNext[1];
            hex2 <= segNext[2];
            hex3 <= segNext[3];
            hex4 <= segNext[4];
            hex5 <= segNext[5];
        end
    end

endmodule

`default_nettype wire

/* rtl/busSystem.sv */
//****************************
// Bus system top level
// Bus controller, data memory, stopwatch,
// LFSR and seven-segment display on one
// shared data bus, all on CLOCK_50
//****************************
`timescale 1ns/1ps
`default_nettype none

module busSystem import busPkg::*; (
    input  logic        CLOCK_50,
    input  logic        rstN,
    input  logic        readEnable,
    input  logic        writeEnable,
    input  byteEnable_t byteEnable,
    input  busWord_t    address,
    input  busWord_t    writeData,
    output busWord_t    readData,
    output logic        readValid,
    input  dispSource_t dispSelect,
    output segment_t    hex0,
    output segment_t    hex1,
    output segment_t    hex2,
    output segment_t    hex3,
    output segment_t    hex4,
    output segment_t    hex5
);

    // Registered request towards the devices
    busIf bus ();

    // Per-device read words
    busWord_t memData;
    busWord_t swData;
    busWord_t lfsrData;
    busWord_t dispData;

    // Stopwatch internals
    busWord_t swCount;
    logic     run;
    logic     clear;

    busController ctrl0 (
        .CLOCK_50   (CLOCK_50),
        .rstN       (rstN),
        .readEnable (readEnable),
        .writeEnable(writeEnable),
        .byteEnable (byteEnable),
        .address    (address),
        .writeData  (writeData),
        .bus        (bus.ctrl),
        .memData    (memData),
        .swData     (swData),
        .lfsrData   (lfsrData),
        .dispData   (dispData),
        .readData   (readData),
        .readValid  (readValid)
    );

    dataMemory mem0 (
        .CLOCK_50(CLOCK_50),
        .bus     (bus.device),
        .rData   (memData)
    );

    // Stopwatch: FSM steers the tick counter
    stopwatchControl swCtrl0 (
        .CLOCK_50(CLOCK_50),
        .rstN    (rstN),
        .bus     (bus.device),
        .run     (run),
        .clear   (clear)
    );

    stopwatchTimer swTimer0 (
        .CLOCK_50(CLOCK_50),
        .rstN    (rstN),
        .bus     (bus.device),
        .run     (run),
        .clear   (clear),
        .rData   (swData),
        .swCount (swCount)
    );

    lfsrGenerator lfsr0 (
        .CLOCK_50(CLOCK_50),
        .rstN    (rstN),
        .bus     (bus.device),
        .rData   (lfsrData)
    );

    displayDriver disp0 (
        .CLOCK_50  (CLOCK_50),
        .rstN      (rstN),
        .bus       (bus.device),
        .swCount   (swCount),
        .dispSelect(dispSelect),
        .rData     (dispData),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5)
    );

endmodule

`default_nettype wire

/* tests/tbBusSystem.sv */
//****************************
// Bus system testbench
// Table-driven bus master with memory,
// LFSR and display models; checks read
// data, read latency and segments
//****************************
`timescale 1ns/1ps
`default_nettype none

`include "busDefines.svh"

module tbBusSystem import busPkg::*; ();

    typedef enum logic [1:0] {opWrite, opRead, opIdle, opDisp} op_t;
    typedef enum logic [2:0] {chkNone, chkExact, chkRange, chkRepeat, chkSegments} check_t;

    // One stimulus row; idle rows hold their cycle count in data
    typedef struct packed {
        op_t         op;
        busWord_t    address;
        busWord_t    data;
        byteEnable_t byteEnable;
        check_t      check;
        busWord_t    expected;
    } row_t;

    // Outstanding read
    typedef struct packed {
        check_t   check;
        busWord_t expected;
        busWord_t low;
        busWord_t high;
    } pending_t;

    // DE1 glyphs, bit 0 = a .. bit 6 = g, active low
    localparam segment_t glyphTable [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    logic        CLOCK_50;
    logic        rstN;
    logic        readEnable;
    logic        writeEnable;
    byteEnable_t byteEnable;
    busWord_t    address;
    busWord_t    writeData;
    busWord_t    readData;
    logic        readValid;
    dispSource_t dispSelect;
    segment_t    hex0;
    segment_t    hex1;
    segment_t    hex2;
    segment_t    hex3;
    segment_t    hex4;
    segment_t    hex5;

    // Reference models
    busWord_t memModel [`MEM_WORDS];
    busWord_t lfsrModel;
    busWord_t dispModel;

    row_t     rows [$];
    pending_t expectQ [$];
    int       strobeQ [$];
    int       cycleCount;
    int       timeoutLimit;
    int       seed;
    int       runCycle;
    int       stopCycle;
    logic     swCounting;
    busWord_t lastData;

    busSystem dut0 (
        .CLOCK_50   (CLOCK_50),
        .rstN       (rstN),
        .readEnable (readEnable),
        .writeEnable(writeEnable),
        .byteEnable (byteEnable),
        .address    (address),
        .writeData  (writeData),
        .readData   (readData),
        .readValid  (readValid),
        .dispSelect (dispSelect),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3),
        .hex4       (hex4),
        .hex5       (hex5)
    );

    // 100 ns period
    always #50 CLOCK_50 = ~CLOCK_50;

    task automatic stopOnFailure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input busWord_t expected, input busWord_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkWordRange(input string name, input busWord_t low, input busWord_t high,
                                  input busWord_t actual);
        if ($isunknown(actual) || actual < low || actual > high) begin
            $display("ERROR at %0t: %s expected %0d..%0d, actual %0d",
                     $time, name, low, high, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkSegments(input string name, input segment_t expected,
                                 input segment_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %b, actual %b", $time, name, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %b, actual %b", $time, name, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
            stopOnFailure();
        end
    endtask

    // Cycle counter and run limit
    always @(posedge CLOCK_50) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: the run did not complete within %0d cycles", timeoutLimit);
            stopOnFailure();
        end
    end

    function automatic logic inMemWindow(input busWord_t addr);
        return addr >= `MEM_BASE && addr < `MEM_BASE + `MEM_WORDS * `BYTE_LANES;
    endfunction

    function automatic int wordIndex(input busWord_t addr);
        return (addr - `MEM_BASE) / `BYTE_LANES;
    endfunction

    function automatic busWord_t memAddr(input int word);
        return `MEM_BASE + word * `BYTE_LANES;
    endfunction

    // Byte lanes with a set enable take the new data
    function automatic busWord_t mergeLanes(input busWord_t old, input busWord_t data,
                                            input byteEnable_t be);
        busWord_t merged;
        merged = old;
        for (int lane = 0; lane < `BYTE_LANES; lane++) begin
            if (be[lane]) begin
                merged[lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    // Galois step: shift right, taps folded in when bit 0 was set
    function automatic busWord_t lfsrStep(input busWord_t value);
        busWord_t shifted;
        shifted = value >> 1;
        if (value[0]) begin
            shifted = shifted ^ `LFSR_TAPS;
        end
        return shifted;
    endfunction

    task automatic pushRow(input op_t op, input busWord_t addr, input busWord_t data,
                           input byteEnable_t be, input check_t check, input busWord_t expected);
        row_t r;
        r.op         = op;
        r.address    = addr;
        r.data       = data;
        r.byteEnable = be;
        r.check      = check;
        r.expected   = expected;
        rows.push_back(r);
    endtask

    task automatic addWrite(input busWord_t addr, input busWord_t data, input byteEnable_t be);
        if (inMemWindow(addr)) begin
            memModel[wordIndex(addr)] = mergeLanes(memModel[wordIndex(addr)], data, be);
        end else if (addr == `DISP_ADDR) begin
            dispModel = mergeLanes(dispModel, data, be);
        end
        pushRow(opWrite, addr, data, be, chkNone, '0);
    endtask

    // Expected word from the models; unmapped gives zero
    task automatic addRead(input busWord_t addr);
        busWord_t expected;
        expected = '0;
        if (inMemWindow(addr)) begin
            expected = memModel[wordIndex(addr)];
        end else if (addr == `LFSR_ADDR) begin
            expected  = lfsrModel;
            lfsrModel = lfsrStep(lfsrModel);
        end else if (addr == `DISP_ADDR) begin
            expected = dispModel;
        end
        pushRow(opRead, addr, '0, '0, chkExact, expected);
    endtask

    task automatic addSwRead(input check_t check, input busWord_t expected);
        pushRow(opRead, `SW_ADDR, '0, '0, check, expected);
    endtask

    task automatic addIdle(input int cycles);
        pushRow(opIdle, '0, cycles, '0, chkNone, '0);
    endtask

    task automatic addDisp(input dispSource_t src);
        pushRow(opDisp, '0, busWord_t'(src), '0, chkSegments,
                (src == dispRegister) ? dispModel : '0);
    endtask

    task automatic buildTable();
        // State after reset
        addSwRead(chkExact, '0);
        addRead(`DISP_ADDR);
        addDisp(dispBlank);
        // Memory, full words then back-to-back reads
        for (int i = 0; i < 8; i++) begin
            addWrite(memAddr((i * 37) % `MEM_WORDS), $random(seed), 4'hF);
        end
        for (int i = 0; i < 8; i++) begin
            addRead(memAddr((i * 37) % `MEM_WORDS));
        end
        // Partial lanes
        addWrite(memAddr(37), $random(seed), 4'b0101);
        addWrite(memAddr(74), $random(seed), 4'b1000);
        addRead(memAddr(37));
        addRead(memAddr(74));
        // Read in the cycle after the write
        addWrite(memAddr(255), $random(seed), 4'hF);
        addRead(memAddr(255));
        repeat (4) addRead(`LFSR_ADDR);
        // Stopwatch clear, run, stop
        addWrite(`SW_ADDR, `SW_CMD_CLEAR, 4'hF);
        addSwRead(chkExact, '0);
        addWrite(`SW_ADDR, `SW_CMD_RUN, 4'hF);
        addIdle(20);
        addSwRead(chkRange, '0);
        addIdle(9);
        addSwRead(chkRange, '0);
        addWrite(`SW_ADDR, `SW_CMD_STOP, 4'hF);
        addIdle(3);
        addSwRead(chkRange, '0);
        addIdle(8);
        addSwRead(chkRepeat, '0);
        addWrite(`SW_ADDR, `SW_CMD_CLEAR, 4'hF);
        addSwRead(chkExact, '0);
        // Display register and sources
        addWrite(`DISP_ADDR, 32'h5A9C_3E71, 4'hF);
        addRead(`DISP_ADDR);
        addDisp(dispRegister);
        addWrite(`DISP_ADDR, 32'h0000_D400, 4'b0010);
        addRead(`DISP_ADDR);
        addWrite(`DISP_ADDR, 32'h008B_F2A6, 4'hF);
        addDisp(dispRegister);
        addDisp(dispBlank);
        addDisp(dispZero);
        // Unmapped, including just past the memory window
        addRead(32'h2000_0000);
        addWrite(32'h2000_0000, 32'hDEAD_BEEF, 4'hF);
        addWrite(`MEM_BASE + `MEM_WORDS * `BYTE_LANES, 32'hDEAD_BEEF, 4'hF);
        addWrite(`DISP_ADDR + 32'h4, 32'hDEAD_BEEF, 4'hF);
        addRead(memAddr(0));
        addRead(`DISP_ADDR);
    endtask

    task automatic checkDigits(input row_t r);
        segment_t shown [6];
        segment_t want;
        shown[0] = hex0;
        shown[1] = hex1;
        shown[2] = hex2;
        shown[3] = hex3;
        shown[4] = hex4;
        shown[5] = hex5;
        for (int i = 0; i < 6; i++) begin
            if (r.data[1:0] == dispBlank) begin
                want = '1;
            end else begin
                want = glyphTable[r.expected[i*4 +: 4]];
            end
            checkSegments($sformatf("hex%0d", i), want, shown[i]);
        end
    endtask

    task automatic applyRow(input row_t r);
        pending_t p;
        int       k;
        @(posedge CLOCK_50);
        readEnable  <= 1'b0;
        writeEnable <= 1'b0;
        case (r.op)
            opWrite: begin
                writeEnable <= 1'b1;
                address     <= r.address;
                writeData   <= r.data;
                byteEnable  <= r.byteEnable;
                // Track when the stopwatch starts and stops
                if (r.address == `SW_ADDR && r.data == `SW_CMD_RUN) begin
                    runCycle   = cycleCount;
                    swCounting = 1'b1;
                end else if (r.address == `SW_ADDR) begin
                    stopCycle  = cycleCount;
                    swCounting = 1'b0;
                end
            end
            opRead: begin
                readEnable <= 1'b1;
                address    <= r.address;
                p.check    = r.check;
                p.expected = r.expected;
                p.low      = '0;
                p.high     = '0;
                if (r.check == chkRange) begin
                    k      = swCounting ? cycleCount - runCycle : stopCycle - runCycle;
                    p.high = k / `SW_TICK_DIV + 1;
                    p.low  = (k / `SW_TICK_DIV > 0) ? k / `SW_TICK_DIV - 1 : 0;
                end
                expectQ.push_back(p);
            end
            opIdle: begin
                repeat (r.data - 1) @(posedge CLOCK_50);
            end
            default: begin
                // Segments settle two cycles after the switch change
                dispSelect <= dispSource_t'(r.data[1:0]);
                repeat (2) @(posedge CLOCK_50);
                @(negedge CLOCK_50);
                checkDigits(r);
            end
        endcase
    endtask

    task automatic checkResponse();
        pending_t p;
        int       strobeCycle;
        if (expectQ.size() == 0 || strobeQ.size() == 0) begin
            $display("readValid was high at %0t with no read outstanding", $time);
            stopOnFailure();
        end else begin
            p           = expectQ.pop_front();
            strobeCycle = strobeQ.pop_front();
            checkCount("read latency", `READ_LATENCY, cycleCount - strobeCycle);
            case (p.check)
                chkExact:  checkWord("readData", p.expected, readData);
                chkRange:  checkWordRange("readData", p.low, p.high, readData);
                chkRepeat: checkWord("readData", lastData, readData);
                default:   ;
            endcase
            lastData = readData;
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge CLOCK_50) begin
        if (rstN && readEnable) begin
            strobeQ.push_back(cycleCount);
        end
        if (readValid) begin
            checkResponse();
        end
    end

    initial begin
        CLOCK_50    = 1'b0;
        rstN        = 1'b0;
        readEnable  = 1'b0;
        writeEnable = 1'b0;
        byteEnable  = '0;
        address     = '0;
        writeData   = '0;
        dispSelect  = dispBlank;
        cycleCount  = 0;
        seed        = 54817;
        runCycle    = 0;
        stopCycle   = 0;
        swCounting  = 1'b0;
        lastData    = '0;
        lfsrModel   = `LFSR_SEED;
        dispModel   = '0;
        buildTable();
        timeoutLimit = 16 + 4 * rows.size() + 50;

        repeat (16) @(posedge CLOCK_50);
        rstN <= 1'b1;
        @(negedge CLOCK_50);
        checkFlag("readValid", 1'b0, readValid);

        for (int i = 0; i < rows.size(); i++) begin
            applyRow(rows[i]);
        end
        @(posedge CLOCK_50);
        readEnable  <= 1'b0;
        writeEnable <= 1'b0;

        // Drain outstanding reads
        while (expectQ.size() != 0) begin
            @(posedge CLOCK_50);
        end
        repeat (2) @(posedge CLOCK_50);
        if (strobeQ.size() != 0) begin
            $display("%0d read strobes were never answered", strobeQ.size());
            stopOnFailure();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/busPkg.sv
common/busIf.sv
rtl/busController.sv
rtl/dataMemory.sv
stopwatch/stopwatchControl.sv
stopwatch/stopwatchTimer.sv
rtl/lfsrGenerator.sv
rtl/displayDriver.sv
rtl/busSystem.sv
tests/tbBusSystem.sv

/* Bender.yml */
package:
  name: bus_system

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/busPkg.sv
      - common/busIf.sv
      - rtl/busController.sv
      - rtl/dataMemory.sv
      - stopwatch/stopwatchControl.sv
      - stopwatch/stopwatchTimer.sv
      - rtl/lfsrGenerator.sv
      - rtl/displayDriver.sv
      - rtl/busSystem.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tbBusSystem.sv
